// ==== source/div_pkg.sv ====
// --------------------
// Integer divider package
// Controller states, SRT digit type and sizing limits
// --------------------
`default_nettype none

package div_pkg;

	// --------------------
	// Controller states
	// --------------------
	// NORM lasts one cycle, STEP runs until the core is done
	typedef enum logic [1:0] {
		IDLE,
		NORM,
		STEP,
		OUT
	} div_state_t;

	// --------------------
	// Radix-2 SRT digit
	// --------------------
	// Digit zero has both bits clear
	typedef struct packed {
		logic pos;
		logic neg;
	} qdigit_t;

	localparam qdigit_t QD_ZERO = '{pos: 1'b0, neg: 1'b0};
	localparam qdigit_t QD_POS  = '{pos: 1'b1, neg: 1'b0};
	localparam qdigit_t QD_NEG  = '{pos: 1'b0, neg: 1'b1};

	// Sizing limits
	// Count width is clog2 of the operand width, capped here
	localparam int LZC_W_MAX = 7;
	// Narrowest operand the datapath supports
	localparam int WIDTH_MIN = 9;
	// Most SRT steps chained in one clock
	localparam int ITERS_MAX = 4;

endpackage

`default_nettype wire

// ==== source/operand_norm.sv ====
// --------------------
// Operand normalizer
// Captures one operand as an absolute value and gives its
// leading-zero count and left-normalized form
// --------------------
`default_nettype none

module operand_norm
	import div_pkg::*;
#(
	parameter int WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_i,
	input  logic                     signed_i,
	input  logic [WIDTH-1:0]         operand_i,
	output logic                     neg_o,
	output logic                     zero_o,
	output logic [$clog2(WIDTH)-1:0] lzc_o,
	output logic [WIDTH-1:0]         norm_o
);

	localparam int LZC_W = $clog2(WIDTH);

	// Width must suit the datapath and the count width
	if (WIDTH < WIDTH_MIN || LZC_W > LZC_W_MAX) begin : g_width_check
		$error("operand_norm: WIDTH outside the supported range");
	end

	logic             op_neg;
	logic             neg_q;
	logic [WIDTH-1:0] abs_q;
	logic [LZC_W-1:0] lzc;
	logic             found;

	// Sign counts only in signed mode
	assign op_neg = signed_i & operand_i[WIDTH-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			neg_q <= 1'b0;
		end else if (load_i) begin
			neg_q <= op_neg;
		end
	end

	// Magnitude register, negated on the way in
	// Most negative value maps onto itself, which is the right unsigned magnitude
	always_ff @(posedge clk) begin
		if (load_i) begin
			abs_q <= op_neg ? -operand_i : operand_i;
		end
	end

	// --------------------
	// Leading-zero count
	// --------------------
	// Scan upward so the highest set bit wins
	always_comb begin
		lzc   = LZC_W'(WIDTH - 1);
		found = 1'b0;
		for (int i = 0; i < WIDTH; i++) begin
			if (abs_q[i]) begin
				lzc   = LZC_W'(WIDTH - 1 - i);
				found = 1'b1;
			end
		end
	end

	assign neg_o  = neg_q;
	// No set bit at all means a zero operand
	assign zero_o = ~found;
	assign lzc_o  = lzc;
	// First one bit moved to the top
	assign norm_o = abs_q << lzc;

endmodule

`default_nettype wire

// ==== source/srt_iter_core.sv ====
// --------------------
// SRT iteration core
// Radix-2 SRT steps, several per clock, with on-the-fly
// quotient conversion and a final sign correction
// --------------------
`default_nettype none

module srt_iter_core
	import div_pkg::*;
#(
	parameter int WIDTH           = 32,
	parameter int ITERS_PER_CYCLE = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_i,
	input  logic [WIDTH-1:0]         rem_norm_i,
	input  logic [WIDTH-1:0]         div_norm_i,
	input  logic [$clog2(WIDTH)-1:0] iter_cnt_i,
	output logic                     done_o,
	output logic [WIDTH-1:0]         quotient_o
);

	localparam int LZC_W = $clog2(WIDTH);
	// Remainder is two bits wider than the operand
	localparam int RW = WIDTH + 2;

	if (ITERS_PER_CYCLE < 1 || ITERS_PER_CYCLE > ITERS_MAX) begin : g_iters_check
		$error("srt_iter_core: ITERS_PER_CYCLE outside the supported range");
	end

	// Registered state
	logic signed [RW-1:0] rem_q;
	logic [WIDTH-1:0]     quot_q;
	logic [WIDTH-1:0]     quot_m1_q;
	logic [LZC_W-1:0]     cnt_q;
	logic                 busy_q;

	// Step chain
	logic signed [RW-1:0] rem_s     [0:ITERS_PER_CYCLE];
	logic [WIDTH-1:0]     quot_s    [0:ITERS_PER_CYCLE];
	logic [WIDTH-1:0]     quot_m1_s [0:ITERS_PER_CYCLE];
	qdigit_t              dig_s     [0:ITERS_PER_CYCLE-1];

	// Chain outputs picked for this cycle
	logic signed [RW-1:0] rem_sel;
	logic [WIDTH-1:0]     quot_sel;
	logic [WIDTH-1:0]     quot_m1_sel;
	logic                 last_cycle;

	// Divisor at the scale of twice the remainder
	logic signed [RW:0]   d_half;
	logic signed [RW:0]   d_full;

	// Remainder carries one extra fraction bit, so the
	// selection threshold is the plain normalized divisor
	assign d_half = {3'b000, div_norm_i};
	assign d_full = {2'b00, div_norm_i, 1'b0};

	// Normalizer output stays put for the whole operation
	assign rem_s[0]     = rem_q;
	assign quot_s[0]    = quot_q;
	assign quot_m1_s[0] = quot_m1_q;

	// --------------------
	// SRT step stages
	// --------------------
	for (genvar i = 0; i < ITERS_PER_CYCLE; i++) begin : g_step
		logic signed [RW:0] rem_x2;
		logic signed [RW:0] rem_nxt;

		assign rem_x2 = {rem_s[i], 1'b0};

		// Digit selection against plus and minus half the divisor
		assign dig_s[i] = (rem_x2 >= d_half)  ? QD_POS :
		                  (rem_x2 < -d_half)  ? QD_NEG : QD_ZERO;

		// Subtract for +1, add for -1, shift only for 0
		assign rem_nxt = dig_s[i].pos ? rem_x2 - d_full :
		                 dig_s[i].neg ? rem_x2 + d_full : rem_x2;

		// Result stays within twice the divisor, top bit drops safely
		assign rem_s[i+1] = rem_nxt[RW-1:0];

		// On-the-fly conversion
		// +1 : Q = {Q,1}, QM = {Q,0}
		//  0 : Q = {Q,0}, QM = {QM,1}
		// -1 : Q = {QM,1}, QM = {QM,0}
		assign quot_s[i+1] = dig_s[i].neg ? {quot_m1_s[i][WIDTH-2:0], 1'b1} :
		                                    {quot_s[i][WIDTH-2:0], dig_s[i].pos};
		assign quot_m1_s[i+1] = dig_s[i].pos ? {quot_s[i][WIDTH-2:0], 1'b0} :
		                                       {quot_m1_s[i][WIDTH-2:0], ~dig_s[i].neg};
	end

	// --------------------
	// Step count
	// --------------------
	// Counter holds remaining steps minus one
	assign last_cycle = (int'(cnt_q) < ITERS_PER_CYCLE);

	// Last cycle takes the chain output after cnt_q + 1 steps
	always_comb begin
		rem_sel     = rem_s[ITERS_PER_CYCLE];
		quot_sel    = quot_s[ITERS_PER_CYCLE];
		quot_m1_sel = quot_m1_s[ITERS_PER_CYCLE];
		if (last_cycle) begin
			for (int k = 1; k < ITERS_PER_CYCLE; k++) begin
				if (int'(cnt_q) == k - 1) begin
					rem_sel     = rem_s[k];
					quot_sel    = quot_s[k];
					quot_m1_sel = quot_m1_s[k];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (load_i) begin
			busy_q <= 1'b1;
			cnt_q  <= iter_cnt_i;
		end else if (busy_q) begin
			busy_q <= ~last_cycle;
			cnt_q  <= cnt_q - LZC_W'(ITERS_PER_CYCLE);
		end
	end

	// Datapath registers
	// Start remainder is half the dividend, one fraction bit down
	always_ff @(posedge clk) begin
		if (load_i) begin
			rem_q     <= {2'b00, rem_norm_i};
			quot_q    <= '0;
			quot_m1_q <= '1;
		end else if (busy_q) begin
			rem_q     <= rem_sel;
			quot_q    <= quot_sel;
			quot_m1_q <= quot_m1_sel;
		end
	end

	assign done_o = busy_q & last_cycle;

	// Negative final remainder means the quotient overshot by one
	assign quotient_o = rem_q[RW-1] ? quot_m1_q : quot_q;

endmodule

`default_nettype wire

// ==== source/div_ctrl.sv ====
// --------------------
// Divider controller
// FSM, start and finish handshakes, special cases
// and the signed result
// --------------------
`default_nettype none

module div_ctrl
	import div_pkg::*;
#(
	parameter int WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start_valid_i,
	input  logic                     signed_op_i,
	input  logic                     finish_ready_i,
	input  logic [$clog2(WIDTH)-1:0] dvd_lzc_i,
	input  logic                     dvd_zero_i,
	input  logic                     dvd_neg_i,
	input  logic [$clog2(WIDTH)-1:0] dvs_lzc_i,
	input  logic                     dvs_zero_i,
	input  logic                     dvs_neg_i,
	input  logic                     done_i,
	input  logic [WIDTH-1:0]         core_quot_i,
	output logic                     start_ready_o,
	output logic                     finish_valid_o,
	output logic                     load_o,
	output logic                     core_load_o,
	output logic [$clog2(WIDTH)-1:0] iter_cnt_o,
	output logic [WIDTH-1:0]         quotient_o,
	output logic                     divisor_is_zero_o
);

	div_state_t       state_q;
	div_state_t       state_d;
	logic             start_xfer;
	logic             finish_xfer;
	logic             too_small;
	logic             special;
	logic             signed_q;
	logic             div_zero_q;
	logic             too_small_q;
	logic             res_neg_q;
	logic [WIDTH-1:0] quot_mag;

	// --------------------
	// Handshakes
	// --------------------
	assign start_ready_o  = (state_q == IDLE);
	assign start_xfer     = start_valid_i & start_ready_o;
	assign finish_valid_o = (state_q == OUT);
	assign finish_xfer    = finish_valid_o & finish_ready_i;

	// Both normalizers capture in the start transfer cycle
	assign load_o = start_xfer;

	// Special cases, valid in NORM
	// Dividend with more leading zeros has the smaller magnitude
	assign too_small = dvd_zero_i | (dvd_lzc_i > dvs_lzc_i);
	assign special   = dvs_zero_i | too_small;

	assign core_load_o = (state_q == NORM) & ~special;
	// Steps minus one, only meaningful without a special case
	assign iter_cnt_o  = dvs_lzc_i - dvd_lzc_i;

	// --------------------
	// State machine
	// --------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start_xfer) begin
					state_d = NORM;
				end
			end
			NORM: begin
				state_d = special ? OUT : STEP;
			end
			STEP: begin
				if (done_i) begin
					state_d = OUT;
				end
			end
			OUT: begin
				// Held here under back-pressure
				if (finish_xfer) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Operation flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			signed_q    <= 1'b0;
			div_zero_q  <= 1'b0;
			too_small_q <= 1'b0;
			res_neg_q   <= 1'b0;
		end else begin
			if (start_xfer) begin
				signed_q <= signed_op_i;
			end
			if (state_q == NORM) begin
				div_zero_q  <= dvs_zero_i;
				too_small_q <= too_small;
				// Quotient is negative when exactly one operand is
				res_neg_q   <= signed_q & (dvd_neg_i ^ dvs_neg_i);
			end
		end
	end

	// --------------------
	// Result
	// --------------------
	// Zero divisor wins over a small dividend
	assign quot_mag = div_zero_q  ? {WIDTH{1'b1}} :
	                  too_small_q ? {WIDTH{1'b0}} : core_quot_i;

	// All-ones result of a zero divisor keeps its sign
	assign quotient_o = (res_neg_q & ~div_zero_q) ? -quot_mag : quot_mag;

	assign divisor_is_zero_o = div_zero_q;

endmodule

`default_nettype wire

// ==== source/int_div_top.sv ====
// --------------------
// Sequential integer divider
// Signed or unsigned quotient through valid/ready handshakes
// --------------------
`default_nettype none

module int_div_top #(
	parameter int WIDTH           = 32,
	parameter int ITERS_PER_CYCLE = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start_valid_i,
	output logic             start_ready_o,
	input  logic             signed_op_i,
	input  logic [WIDTH-1:0] dividend_i,
	input  logic [WIDTH-1:0] divisor_i,
	output logic             finish_valid_o,
	input  logic             finish_ready_i,
	output logic [WIDTH-1:0] quotient_o,
	output logic             divisor_is_zero_o
);

	localparam int LZC_W = $clog2(WIDTH);

	// Normalizer capture strobe
	logic             load;

	// Dividend side
	logic             dvd_neg;
	logic             dvd_zero;
	logic [LZC_W-1:0] dvd_lzc;
	logic [WIDTH-1:0] dvd_norm;

	// Divisor side
	logic             dvs_neg;
	logic             dvs_zero;
	logic [LZC_W-1:0] dvs_lzc;
	logic [WIDTH-1:0] dvs_norm;

	// Core control and result
	logic             core_load;
	logic [LZC_W-1:0] iter_cnt;
	logic             core_done;
	logic [WIDTH-1:0] core_quot;

	// --------------------
	// Operand normalizers
	// --------------------
	operand_norm #(
		.WIDTH (WIDTH)
	) u_norm_dividend (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_i    (load),
		.signed_i  (signed_op_i),
		.operand_i (dividend_i),
		.neg_o     (dvd_neg),
		.zero_o    (dvd_zero),
		.lzc_o     (dvd_lzc),
		.norm_o    (dvd_norm)
	);

	operand_norm #(
		.WIDTH (WIDTH)
	) u_norm_divisor (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_i    (load),
		.signed_i  (signed_op_i),
		.operand_i (divisor_i),
		.neg_o     (dvs_neg),
		.zero_o    (dvs_zero),
		.lzc_o     (dvs_lzc),
		.norm_o    (dvs_norm)
	);

	// --------------------
	// Iteration core
	// --------------------
	srt_iter_core #(
		.WIDTH           (WIDTH),
		.ITERS_PER_CYCLE (ITERS_PER_CYCLE)
	) u_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_i     (core_load),
		.rem_norm_i (dvd_norm),
		.div_norm_i (dvs_norm),
		.iter_cnt_i (iter_cnt),
		.done_o     (core_done),
		.quotient_o (core_quot)
	);

	// Controller
	div_ctrl #(
		.WIDTH (WIDTH)
	) u_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.start_valid_i     (start_valid_i),
		.signed_op_i       (signed_op_i),
		.finish_ready_i    (finish_ready_i),
		.dvd_lzc_i         (dvd_lzc),
		.dvd_zero_i        (dvd_zero),
		.dvd_neg_i         (dvd_neg),
		.dvs_lzc_i         (dvs_lzc),
		.dvs_zero_i        (dvs_zero),
		.dvs_neg_i         (dvs_neg),
		.done_i            (core_done),
		.core_quot_i       (core_quot),
		.start_ready_o     (start_ready_o),
		.finish_valid_o    (finish_valid_o),
		.load_o            (load),
		.core_load_o       (core_load),
		.iter_cnt_o        (iter_cnt),
		.quotient_o        (quotient_o),
		.divisor_is_zero_o (divisor_is_zero_o)
	);

endmodule

`default_nettype wire

// ==== tb/int_div_asserts.sv ====
// --------------------
// Divider handshake assertions
// Reset values, result hold under back-pressure, start blocking
// --------------------
`default_nettype none

module int_div_asserts #(
	parameter int WIDTH = 32
) (
	input logic             clk,
	input logic             rst_n,
	input logic             start_valid_i,
	input logic             start_ready_o,
	input logic             finish_valid_o,
	input logic             finish_ready_i,
	input logic [WIDTH-1:0] quotient_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Idle handshake state during reset and right after it
	assert property (@(posedge clk) !rst_n |-> (start_ready_o && !finish_valid_o))
		else $error("Handshake outputs not idle during reset");
	assert property (@(posedge clk) $rose(rst_n) |-> (start_ready_o && !finish_valid_o))
		else $error("Handshake outputs not idle after reset release");

	// Result held until the finish transfer
	assert property (@(posedge clk) disable iff (!rst_n)
		(finish_valid_o && !finish_ready_i) |=> (finish_valid_o && $stable(quotient_o)))
		else $error("Result changed or dropped under back-pressure");

	// Next start accepted in the cycle after the finish transfer
	assert property (@(posedge clk) disable iff (!rst_n)
		(finish_valid_o && finish_ready_i) |=> (start_ready_o && !finish_valid_o))
		else $error("Not ready for a new start after the finish transfer");

	// One operation at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		(start_valid_i && start_ready_o) |=> !start_ready_o)
		else $error("Start ready stayed high after a start transfer");

endmodule

`default_nettype wire

// ==== tb/int_div_tb.sv ====
// --------------------
// Integer divider testbench
// Directed cases from a file, then seeded random cases
// --------------------
`default_nettype none

module int_div_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          WIDTH        = 32;
	localparam int          ITERS        = 4;
	localparam int          CLK_PERIOD   = 4;
	localparam int          RESET_CYCLES = 10;
	localparam int          MAX_DELAY    = 5;
	localparam int          N_RANDOM     = 200;
	localparam int unsigned SEED         = 32'h6d3f_6384;
	localparam string       CASE_FILE    = "tb/div_cases.txt";

	logic             clk = 1'b0;
	logic             rst_n;
	logic             start_valid_i;
	logic             start_ready_o;
	logic             signed_op_i;
	logic [WIDTH-1:0] dividend_i;
	logic [WIDTH-1:0] divisor_i;
	logic             finish_valid_o;
	logic             finish_ready_i;
	logic [WIDTH-1:0] quotient_o;
	logic             divisor_is_zero_o;

	int value_errs  = 0;
	int other_errs  = 0;
	int n_cases     = 0;
	int cycle_cnt   = 0;
	int cycle_limit = 0;

	// Cases read from the file
	logic             sgn_list [$];
	logic [WIDTH-1:0] dvd_list [$];
	logic [WIDTH-1:0] dvs_list [$];
	logic [WIDTH-1:0] q_list   [$];
	logic             z_list   [$];

	always #(CLK_PERIOD / 2) clk = ~clk;

	int_div_top #(
		.WIDTH           (WIDTH),
		.ITERS_PER_CYCLE (ITERS)
	) UUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.start_valid_i     (start_valid_i),
		.start_ready_o     (start_ready_o),
		.signed_op_i       (signed_op_i),
		.dividend_i        (dividend_i),
		.divisor_i         (divisor_i),
		.finish_valid_o    (finish_valid_o),
		.finish_ready_i    (finish_ready_i),
		.quotient_o        (quotient_o),
		.divisor_is_zero_o (divisor_is_zero_o)
	);

	bind int_div_top int_div_asserts #(
		.WIDTH (WIDTH)
	) u_asserts (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o),
		.finish_ready_i (finish_ready_i),
		.quotient_o     (quotient_o)
	);

	// --------------------
	// Timeout
	// --------------------
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------
	// Reference model
	// --------------------
	// Operand magnitude, sign counts in signed mode only
	function automatic logic [WIDTH-1:0] magnitude(input logic sgn, input logic [WIDTH-1:0] v);
		if (sgn && v[WIDTH-1]) begin
			return -v;
		end
		return v;
	endfunction

	function automatic int lead_zeros(input logic [WIDTH-1:0] v);
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (v[i]) begin
				return WIDTH - 1 - i;
			end
		end
		return WIDTH;
	endfunction

	// Truncating division, all ones on a zero divisor
	function automatic logic [WIDTH-1:0] model_quotient(input logic sgn,
			input logic [WIDTH-1:0] dvd, input logic [WIDTH-1:0] dvs);
		logic [WIDTH-1:0] mq;
		if (dvs == '0) begin
			return '1;
		end
		mq = magnitude(sgn, dvd) / magnitude(sgn, dvs);
		if (sgn && (dvd[WIDTH-1] ^ dvs[WIDTH-1])) begin
			return -mq;
		end
		return mq;
	endfunction

	// Cycles from the start transfer to finish valid
	function automatic int model_latency(input logic sgn,
			input logic [WIDTH-1:0] dvd, input logic [WIDTH-1:0] dvs);
		logic [WIDTH-1:0] a;
		logic [WIDTH-1:0] b;
		a = magnitude(sgn, dvd);
		b = magnitude(sgn, dvs);
		if (b == '0 || a == '0 || lead_zeros(a) > lead_zeros(b)) begin
			return 2;
		end
		// Steps are the count difference plus one, ITERS per cycle
		return 2 + (lead_zeros(b) - lead_zeros(a) + ITERS) / ITERS;
	endfunction

	// --------------------
	// One operation with back-pressure
	// --------------------
	task automatic run_case(input string name, input logic sgn, input logic [WIDTH-1:0] dvd,
			input logic [WIDTH-1:0] dvs, input logic [WIDTH-1:0] exp_q, input logic exp_z);
		int               lat;
		int               exp_lat;
		int               delay;
		logic [WIDTH-1:0] held_q;
		exp_lat = model_latency(sgn, dvd, dvs);
		delay   = int'($urandom_range(MAX_DELAY, 0));
		n_cases++;
		while (!start_ready_o) begin
			@(negedge clk);
		end
		start_valid_i = 1'b1;
		signed_op_i   = sgn;
		dividend_i    = dvd;
		divisor_i     = dvs;
		@(negedge clk);
		// Scrambled data outside the transfer cycle
		start_valid_i = 1'b0;
		signed_op_i   = ~sgn;
		dividend_i    = ~dvd;
		divisor_i     = ~dvs;
		lat = 1;
		while (!finish_valid_o) begin
			@(negedge clk);
			lat++;
		end
		if (lat != exp_lat) begin
			$display("FAIL %s latency: expected %0d, actual %0d", name, exp_lat, lat);
			value_errs++;
		end
		if (quotient_o !== exp_q) begin
			$display("FAIL %s quotient: expected %h, actual %h", name, exp_q, quotient_o);
			value_errs++;
		end
		if (divisor_is_zero_o !== exp_z) begin
			$display("FAIL %s zero flag: expected %0d, actual %0d", name, exp_z,
				divisor_is_zero_o);
			value_errs++;
		end
		held_q = quotient_o;
		// Hold the result while finish ready stays low
		for (int i = 0; i < delay; i++) begin
			@(negedge clk);
			if (!finish_valid_o) begin
				$display("Error in %s: finish_valid_o fell before the finish transfer", name);
				other_errs++;
			end
			if (start_ready_o) begin
				$display("Error in %s: start_ready_o rose before the finish transfer", name);
				other_errs++;
			end
			if (quotient_o !== held_q) begin
				$display("FAIL %s held quotient: expected %h, actual %h", name, held_q,
					quotient_o);
				value_errs++;
			end
		end
		finish_ready_i = 1'b1;
		@(negedge clk);
		finish_ready_i = 1'b0;
		if (finish_valid_o) begin
			$display("Error in %s: finish_valid_o stayed high after the finish transfer", name);
			other_errs++;
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		int               fd;
		string            line;
		logic [WIDTH-1:0] f_sgn;
		logic [WIDTH-1:0] f_dvd;
		logic [WIDTH-1:0] f_dvs;
		logic [WIDTH-1:0] f_q;
		logic [WIDTH-1:0] f_z;
		logic             r_sgn;
		logic [WIDTH-1:0] r_dvd;
		logic [WIDTH-1:0] r_dvs;
		void'($urandom(SEED));
		rst_n          = 1'b0;
		start_valid_i  = 1'b0;
		signed_op_i    = 1'b0;
		dividend_i     = '0;
		divisor_i      = '0;
		finish_ready_i = 1'b0;

		// Comment and blank lines do not scan as five fields
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s for reading", CASE_FILE);
			other_errs++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%h %h %h %h %h", f_sgn, f_dvd, f_dvs, f_q, f_z) == 5) begin
					sgn_list.push_back(f_sgn[0]);
					dvd_list.push_back(f_dvd);
					dvs_list.push_back(f_dvs);
					q_list.push_back(f_q);
					z_list.push_back(f_z[0]);
				end
			end
			$fclose(fd);
		end
		if (sgn_list.size() == 0) begin
			$display("No cases could be read from %s", CASE_FILE);
			other_errs++;
		end
		cycle_limit = (sgn_list.size() + N_RANDOM) * (WIDTH / ITERS + 4 + MAX_DELAY)
			+ RESET_CYCLES;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		for (int i = 0; i < sgn_list.size(); i++) begin
			run_case($sformatf("file case %0d", i), sgn_list[i], dvd_list[i], dvs_list[i],
				q_list[i], z_list[i]);
		end

		// Random shifts spread the leading-zero counts
		for (int i = 0; i < N_RANDOM; i++) begin
			r_sgn = 1'($urandom % 2);
			r_dvd = $urandom >> ($urandom % WIDTH);
			r_dvs = $urandom >> ($urandom % WIDTH);
			if ($urandom % 16 == 0) begin
				r_dvs = '0;
			end
			run_case($sformatf("random case %0d", i), r_sgn, r_dvd, r_dvs,
				model_quotient(r_sgn, r_dvd, r_dvs), r_dvs == '0);
		end

		$display("Cases: %0d, value errors: %0d, other errors: %0d", n_cases, value_errs,
			other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/div_cases.txt ====
// signed dividend divisor expected_quotient expected_zero_flag, all hex
// signed 1 means two's complement operands
0 00000064 00000007 0000000e 0
0 12345678 12345678 00000001 0
0 deadbeef 00000001 deadbeef 0
0 ffffffff 00000002 7fffffff 0
0 ffffffff ffffffff 00000001 0
0 80000000 00000003 2aaaaaaa 0
0 00000007 00000004 00000001 0
0 00000004 00000007 00000000 0
0 00000003 00000007 00000000 0
0 00000000 00000009 00000000 0
0 0000ffff 00010000 00000000 0
0 00000005 00000000 ffffffff 1
1 00000064 00000007 0000000e 0
1 ffffff9c 00000007 fffffff2 0
1 00000064 fffffff9 fffffff2 0
1 ffffff9c fffffff9 0000000e 0
1 80000000 ffffffff 80000000 0
1 80000000 00000001 80000000 0
1 80000000 80000000 00000001 0
1 ffffffff 00000001 ffffffff 0
1 7fffffff 80000000 00000000 0
1 fffffffd 00000007 00000000 0
1 fffffff9 00000000 ffffffff 1
1 00000000 00000000 ffffffff 1

// ==== filelist.f ====
source/div_pkg.sv
source/operand_norm.sv
source/srt_iter_core.sv
source/div_ctrl.sv
source/int_div_top.sv
tb/int_div_asserts.sv
tb/int_div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the divider testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module int_div_tb -f filelist.f -o int_div_sim &&
	./obj_dir/int_div_sim | tee /dev/stderr | grep -q "NO ERRORS" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
